/* files.f */
src/regfile_pkg.sv
src/bus_wr_align.sv
src/regfile_2p.sv
src/rd_extract.sv
src/regfile_top.sv
sim/regfile_props.sv
sim/tb_regfile.sv

/* sim/regfile_props.sv */
`timescale 1ns/1ps
`default_nettype none

module regfile_props
   import regfile_pkg::*;
#(
   parameter int ADDR_W = 4
) (
   input wire logic              clk_i,
   input wire logic              rst_n_i,
   input wire logic              wr_en_i,
   input wire logic [ADDR_W-1:0] wr_addr_i,
   input wire acc_size_t         wr_size_i,
   input wire logic              wr_err_i,
   input wire logic              req_en_i,   // en field of the internal write request
   input wire logic              rd_en_i,
   input wire logic              rd_valid_i,
   input wire logic              rd_err_i
);

   int unsigned fails = 0;   // failed assertions so far
   logic        wr_bad;

   // halfword at an odd address or word off a row boundary
   assign wr_bad = wr_en_i & (((wr_size_i == SIZE_HALF) & wr_addr_i[0])
                 | ((wr_size_i == SIZE_WORD) & (wr_addr_i[1:0] != 2'b00)));

   a_rd_valid_follows: assert property (@(posedge clk_i) disable iff (!rst_n_i)
      rd_en_i |=> rd_valid_i)
      else begin
         $error("rd_valid_o missing one cycle after rd_en_i");
         fails++;
      end

   a_rd_valid_cause: assert property (@(posedge clk_i) disable iff (!rst_n_i)
      rd_valid_i |-> $past(rd_en_i))
      else begin
         $error("rd_valid_o without a read strobe in the cycle before");
         fails++;
      end

   // outputs clear one edge after a sampled reset
   a_reset_quiet: assert property (@(posedge clk_i)
      !rst_n_i |=> (!rd_valid_i && !rd_err_i && !wr_err_i && !req_en_i))
      else begin
         $error("outputs not low after reset");
         fails++;
      end

   a_bad_write_dropped: assert property (@(posedge clk_i) disable iff (!rst_n_i)
      wr_bad |=> (wr_err_i && !req_en_i))
      else begin
         $error("misaligned write not flagged or not dropped");
         fails++;
      end

endmodule

bind regfile_top regfile_props #(
   .ADDR_W(ADDR_W)
) props_i (
   .clk_i     (clk_i),
   .rst_n_i   (rst_n_i),
   .wr_en_i   (wr_en_i),
   .wr_addr_i (wr_addr_i),
   .wr_size_i (wr_size_i),
   .wr_err_i  (wr_err_o),
   .req_en_i  (wr_req.en),
   .rd_en_i   (rd_en_i),
   .rd_valid_i(rd_valid_o),
   .rd_err_i  (rd_err_o)
);

`default_nettype wire

/* sim/tb_regfile.sv */
`timescale 1ns/1ps
`default_nettype none

module tb_regfile
   import regfile_pkg::*;
;

   localparam int N           = 16;
   localparam int ADDR_W      = 4;
   localparam int DRAIN_LIMIT = 20;    // cycles
   localparam int RAND_OPS    = 400;

   typedef struct packed {
      logic [31:0] tag;   // cycle in which the response is due
      word_t       data;
      logic        err;
   } rd_exp_t;

   typedef struct packed {
      logic [31:0] tag;
      logic        err;
   } wr_exp_t;

   typedef struct packed {
      logic              en;
      logic [ADDR_W-1:0] addr;
      acc_size_t         size;
      word_t             data;   // right-justified
   } wr_op_t;

   typedef struct packed {
      logic              wr;
      logic [ADDR_W-1:0] addr;
      acc_size_t         size;
      logic              sgn;
      word_t             data;
      word_t             exp;
      logic              err;
   } tbl_entry_t;

   logic              clk = 1'b0;
   logic              rst_n;
   logic              wr_en;
   logic [ADDR_W-1:0] wr_addr;
   acc_size_t         wr_size;
   word_t             wr_data;
   logic              wr_err_o;
   logic              rd_en;
   logic [ADDR_W-1:0] rd_addr;
   acc_size_t         rd_size;
   logic              rd_sgn;
   word_t             rd_data_o;
   logic              rd_valid_o;
   logic              rd_err_o;

   logic [7:0]  mem_model [N];
   rd_exp_t     rd_q [$];
   wr_exp_t     wr_q [$];
   tbl_entry_t  tbl [$];
   wr_op_t      pend;          // issued last cycle but not yet in the model
   wr_op_t      cur;
   logic [31:0] cyc = 0;
   logic [31:0] lfsr = 32'h184a_ffe7;
   logic        mon_on = 1'b0;
   logic        rd_due;
   logic        wr_due;
   rd_exp_t     rd_head;
   wr_exp_t     wr_head;

   always #2 clk = ~clk;
   always @(posedge clk) cyc <= cyc + 1;

   regfile_top #(
      .N     (N),
      .ADDR_W(ADDR_W)
   ) dut_i (
      .clk_i     (clk),
      .rst_n_i   (rst_n),
      .wr_en_i   (wr_en),
      .wr_addr_i (wr_addr),
      .wr_size_i (wr_size),
      .wr_data_i (wr_data),
      .wr_err_o  (wr_err_o),
      .rd_en_i   (rd_en),
      .rd_addr_i (rd_addr),
      .rd_size_i (rd_size),
      .rd_sgn_i  (rd_sgn),
      .rd_data_o (rd_data_o),
      .rd_valid_o(rd_valid_o),
      .rd_err_o  (rd_err_o)
   );

   task automatic check(input logic [31:0] got, input logic [31:0] exp, input string what);
      if (got !== exp) begin
         $display("Error at %0d ns: %s is %h, expected %h", $time, what, got, exp);
         $display("Testbench failed");
         $fatal(1);
      end
   endtask

   // fibonacci lfsr with taps 32 22 2 1
   function automatic logic [31:0] lfsr_step(logic [31:0] s);
      return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};
   endfunction

   function automatic logic [31:0] take_bits(int n);
      logic [31:0] v;
      v = '0;
      for (int k = 0; k < n; k++) begin
         lfsr = lfsr_step(lfsr);
         v = {v[30:0], lfsr[0]};
      end
      return v;
   endfunction

   function automatic acc_size_t size_from_bits(logic [1:0] b);
      if (b == 2'd0) return SIZE_BYTE;
      if (b == 2'd1) return SIZE_HALF;
      return SIZE_WORD;   // 2 and 3 both map to word
   endfunction

   function automatic logic is_misaligned(acc_size_t size, logic [ADDR_W-1:0] addr);
      if (size == SIZE_HALF) return addr[0];
      if (size == SIZE_WORD) return addr[1:0] != 2'b00;
      return 1'b0;
   endfunction

   function automatic word_t model_read(logic [ADDR_W-1:0] addr, acc_size_t size, logic sgn);
      int    a;
      word_t v;
      a = addr;
      case (size)
         SIZE_BYTE: v = {{24{sgn & mem_model[a][7]}}, mem_model[a]};
         SIZE_HALF: v = {{16{sgn & mem_model[a+1][7]}}, mem_model[a+1], mem_model[a]};
         default:   v = {mem_model[a+3], mem_model[a+2], mem_model[a+1], mem_model[a]};
      endcase
      return v;
   endfunction

   task automatic model_write(logic [ADDR_W-1:0] addr, acc_size_t size, word_t data);
      int nb;
      nb = (size == SIZE_BYTE) ? 1 : (size == SIZE_HALF) ? 2 : 4;
      for (int i = 0; i < nb; i++) begin
         mem_model[int'(addr) + i] = data[8*i +: 8];
      end
   endtask

   function automatic logic [7:0] fill_byte(int a);
      return 8'(a * 8'h11) ^ 8'h3c;   // top bit set in the upper half
   endfunction

   function automatic tbl_entry_t make_entry(logic wr, logic [ADDR_W-1:0] addr,
         acc_size_t size, logic sgn, word_t data, word_t exp, logic err);
      tbl_entry_t e;
      e.wr   = wr;
      e.addr = addr;
      e.size = size;
      e.sgn  = sgn;
      e.data = data;
      e.exp  = exp;
      e.err  = err;
      return e;
   endfunction

   task automatic issue_write(logic [ADDR_W-1:0] addr, acc_size_t size, word_t data,
         logic exp_err);
      wr_exp_t we;
      we.tag = cyc + 1;
      we.err = exp_err;
      wr_q.push_back(we);
      cur.en   = !exp_err;
      cur.addr = addr;
      cur.size = size;
      cur.data = data;
      wr_en   = 1'b1;
      wr_addr = addr;
      wr_size = size;
      wr_data = data;
   endtask

   task automatic issue_read(logic [ADDR_W-1:0] addr, acc_size_t size, logic sgn,
         word_t exp_data, logic exp_err);
      rd_exp_t re;
      re.tag  = cyc + 1;
      re.data = exp_data;
      re.err  = exp_err;
      rd_q.push_back(re);
      rd_en   = 1'b1;
      rd_addr = addr;
      rd_size = size;
      rd_sgn  = sgn;
   endtask

   // model trails the bank by one cycle like the write pipeline
   task automatic tick();
      if (pend.en) model_write(pend.addr, pend.size, pend.data);
      pend = cur;
      cur  = '0;
      @(posedge clk);
      #1;
      wr_en = 1'b0;
      rd_en = 1'b0;
   endtask

   task automatic drain();
      int n;
      n = 0;
      while (rd_q.size() != 0 || wr_q.size() != 0) begin
         if (n >= DRAIN_LIMIT) begin
            $display("Timeout: no response from the DUT on rd_valid_o or wr_err_o");
            $display("Testbench failed");
            $fatal(1);
         end else begin
            tick();
            n++;
         end
      end
   endtask

   task automatic load_table();
      tbl.push_back(make_entry(1, 0,  SIZE_WORD, 0, 32'h8765_4321, '0, 0));
      tbl.push_back(make_entry(0, 0,  SIZE_WORD, 0, '0, 32'h8765_4321, 0));
      tbl.push_back(make_entry(1, 5,  SIZE_BYTE, 0, 32'hffff_ff9c, '0, 0));
      tbl.push_back(make_entry(0, 4,  SIZE_WORD, 0, '0, 32'h0000_9c00, 0));
      tbl.push_back(make_entry(0, 5,  SIZE_BYTE, 1, '0, 32'hffff_ff9c, 0));
      tbl.push_back(make_entry(0, 5,  SIZE_BYTE, 0, '0, 32'h0000_009c, 0));
      tbl.push_back(make_entry(1, 10, SIZE_HALF, 0, 32'h1234_c3a5, '0, 0));
      tbl.push_back(make_entry(0, 8,  SIZE_WORD, 0, '0, 32'hc3a5_0000, 0));
      tbl.push_back(make_entry(0, 10, SIZE_HALF, 1, '0, 32'hffff_c3a5, 0));
      tbl.push_back(make_entry(0, 10, SIZE_HALF, 0, '0, 32'h0000_c3a5, 0));
      tbl.push_back(make_entry(0, 0,  SIZE_HALF, 1, '0, 32'h0000_4321, 0));
      tbl.push_back(make_entry(0, 2,  SIZE_HALF, 1, '0, 32'hffff_8765, 0));
      tbl.push_back(make_entry(0, 3,  SIZE_BYTE, 1, '0, 32'hffff_ff87, 0));
      tbl.push_back(make_entry(0, 1,  SIZE_BYTE, 0, '0, 32'h0000_0043, 0));
      tbl.push_back(make_entry(1, 1,  SIZE_HALF, 0, 32'h0000_1111, '0, 1));  // odd half
      tbl.push_back(make_entry(1, 6,  SIZE_WORD, 0, 32'h2222_2222, '0, 1));
      tbl.push_back(make_entry(0, 4,  SIZE_WORD, 0, '0, 32'h0000_9c00, 0));
      tbl.push_back(make_entry(0, 3,  SIZE_HALF, 0, '0, 32'h0000_0000, 1));
      tbl.push_back(make_entry(0, 2,  SIZE_WORD, 0, '0, 32'h0000_0000, 1));
      tbl.push_back(make_entry(1, 15, SIZE_BYTE, 0, 32'h0000_0080, '0, 0));
      tbl.push_back(make_entry(0, 15, SIZE_BYTE, 1, '0, 32'hffff_ff80, 0));
      tbl.push_back(make_entry(0, 12, SIZE_WORD, 0, '0, 32'h8000_0000, 0));
      tbl.push_back(make_entry(1, 2,  SIZE_HALF, 0, 32'h0000_00ff, '0, 0));
      tbl.push_back(make_entry(0, 0,  SIZE_WORD, 0, '0, 32'h00ff_4321, 0));
      tbl.push_back(make_entry(0, 2,  SIZE_HALF, 1, '0, 32'h0000_00ff, 0));
   endtask

   // responses are checked mid-cycle against the queued expectations
   always @(negedge clk) begin
      if (mon_on) begin
         rd_due = (rd_q.size() != 0) && (rd_q[0].tag == cyc);
         check(rd_valid_o, rd_due, "rd_valid_o");
         if (rd_due) begin
            rd_head = rd_q.pop_front();
            check(rd_data_o, rd_head.data, "rd_data_o");
            check(rd_err_o, rd_head.err, "rd_err_o");
         end
         wr_due = (wr_q.size() != 0) && (wr_q[0].tag == cyc);
         if (wr_due) begin
            wr_head = wr_q.pop_front();
            check(wr_err_o, wr_head.err, "wr_err_o");
         end else begin
            check(wr_err_o, 1'b0, "wr_err_o");
         end
      end
   end

   initial begin
      logic [7:0]        old_b;
      logic [ADDR_W-1:0] a;
      acc_size_t         sz;
      logic              sg;
      logic              mis;
      rst_n   = 1'b0;
      wr_en   = 1'b0;
      wr_addr = '0;
      wr_size = SIZE_BYTE;
      wr_data = '0;
      rd_en   = 1'b0;
      rd_addr = '0;
      rd_size = SIZE_BYTE;
      rd_sgn  = 1'b0;
      pend    = '0;
      cur     = '0;
      for (int i = 0; i < N; i++) mem_model[i] = 8'h00;
      load_table();

      repeat (3) @(posedge clk);
      #1;
      rst_n  = 1'b1;
      mon_on = 1'b1;

      // bank is clear after reset
      for (int r = 0; r < N / 4; r++) begin
         issue_read(ADDR_W'(4 * r), SIZE_WORD, 1'b0, 32'h0, 1'b0);
         tick();
      end
      drain();

      foreach (tbl[i]) begin
         if (tbl[i].wr) begin
            issue_write(tbl[i].addr, tbl[i].size, tbl[i].data, tbl[i].err);
         end else begin
            issue_read(tbl[i].addr, tbl[i].size, tbl[i].sgn, tbl[i].exp, tbl[i].err);
         end
         tick();
         drain();
      end

      // every legal byte and halfword offset with both extensions
      for (int r = 0; r < N / 4; r++) begin
         issue_write(ADDR_W'(4 * r), SIZE_WORD, {fill_byte(4*r+3), fill_byte(4*r+2),
            fill_byte(4*r+1), fill_byte(4*r)}, 1'b0);
         tick();
      end
      drain();
      for (int i = 0; i < N; i++) begin
         for (int s = 0; s < 2; s++) begin
            issue_read(ADDR_W'(i), SIZE_BYTE, s[0], model_read(ADDR_W'(i), SIZE_BYTE, s[0]), 0);
            tick();
            if (i % 2 == 0) begin
               issue_read(ADDR_W'(i), SIZE_HALF, s[0],
                  model_read(ADDR_W'(i), SIZE_HALF, s[0]), 1'b0);
               tick();
            end
         end
      end
      drain();

      // a read one cycle after a write sees old data and two cycles after sees new
      old_b = mem_model[6];
      issue_write(6, SIZE_BYTE, 32'h0000_00e1, 1'b0);
      tick();
      issue_read(6, SIZE_BYTE, 1'b0, {24'h0, old_b}, 1'b0);
      tick();
      issue_read(6, SIZE_BYTE, 1'b0, 32'h0000_00e1, 1'b0);
      tick();
      drain();

      // random back to back traffic
      for (int i = 0; i < RAND_OPS; i++) begin
         if (take_bits(1)) begin
            a  = ADDR_W'(take_bits(ADDR_W));
            sz = size_from_bits(2'(take_bits(2)));
            issue_write(a, sz, take_bits(32), is_misaligned(sz, a));
         end
         if (take_bits(1)) begin
            a   = ADDR_W'(take_bits(ADDR_W));
            sz  = size_from_bits(2'(take_bits(2)));
            sg  = 1'(take_bits(1));
            mis = is_misaligned(sz, a);
            issue_read(a, sz, sg, mis ? 32'h0 : model_read(a, sz, sg), mis);
         end
         tick();
      end
      drain();

      if (dut_i.props_i.fails != 0) begin
         $display("Assertion failures reported by the property checker");
         $display("Testbench failed");
         $fatal(1);
      end else begin
         $display("Testbench passed");
         $finish;
      end
   end

endmodule

`default_nettype wire

/* src/bus_wr_align.sv */
`timescale 1ns/1ps
`default_nettype none

module bus_wr_align
   import regfile_pkg::*;
#(
   parameter int ADDR_W = 4   // byte address width
) (
   input  wire logic              clk_i,
   input  wire logic              rst_n_i,
   input  wire logic              wr_en_i,
   input  wire logic [ADDR_W-1:0] wr_addr_i,
   input  wire acc_size_t         wr_size_i,
   input  wire word_t             wr_data_i,
   output wr_req_t                wr_req_o,
   output logic                   wr_err_o
);

   logic [1:0] off;
   logic       bad;
   word_t      data_rj;     // right-justified, masked to the size
   word_t      lane_data;
   strb_t      strb_base;
   strb_t      strb_nxt;
   row_t       row_nxt;

   // registered request
   logic       en_q;
   logic       err_q;
   row_t       row_q;
   strb_t      strb_q;
   word_t      data_q;

   assign off = wr_addr_i[1:0];
   assign bad = misaligned(wr_size_i, off);

   always_comb begin
      case (wr_size_i)
         SIZE_BYTE: begin
            data_rj   = {{(DATA_W-8){1'b0}}, wr_data_i[7:0]};
            strb_base = strb_t'(4'b0001);
         end
         SIZE_HALF: begin
            data_rj   = {{(DATA_W-16){1'b0}}, wr_data_i[15:0]};
            strb_base = strb_t'(4'b0011);
         end
         SIZE_WORD: begin
            data_rj   = wr_data_i;
            strb_base = '1;
         end
         default: begin
            data_rj   = '0;
            strb_base = '0;
         end
      endcase
   end

   // move the field up to the lanes of its byte offset
   assign lane_data = data_rj << {off, 3'b000};
   assign strb_nxt  = strb_base << off;

   always_comb begin
      row_nxt = '0;
      row_nxt[ADDR_W-3:0] = wr_addr_i[ADDR_W-1:2];   // word index within the bank
   end

   // control state
   always_ff @(posedge clk_i) begin
      if (!rst_n_i) begin
         en_q  <= 1'b0;
         err_q <= 1'b0;
      end else begin
         en_q  <= wr_en_i & ~bad;
         err_q <= wr_en_i & bad;    // single cycle pulse per bad strobe
      end
   end

   // payload, only loaded on a strobe
   always_ff @(posedge clk_i) begin
      if (wr_en_i) begin
         row_q  <= row_nxt;
         strb_q <= strb_nxt;
         data_q <= lane_data;
      end
   end

   assign wr_req_o.en   = en_q;
   assign wr_req_o.row  = row_q;
   assign wr_req_o.strb = strb_q;
   assign wr_req_o.data = data_q;
   assign wr_err_o      = err_q;

endmodule

`default_nettype wire

/* src/rd_extract.sv */
`timescale 1ns/1ps
`default_nettype none

module rd_extract
   import regfile_pkg::*;
#(
   parameter int ADDR_W = 4   // byte address width
) (
   input  wire logic              clk_i,
   input  wire logic              rst_n_i,
   input  wire logic              rd_en_i,
   input  wire rd_cmd_t           rd_cmd_i,
   output logic [ADDR_W-3:0]      rd_row_o,
   input  wire word_t             row_data_i,
   output word_t                  rd_data_o,
   output logic                   rd_valid_o,
   output logic                   rd_err_o
);

   logic [1:0] off;
   logic       bad;
   logic       sgn;
   word_t      shifted;     // addressed byte moved down to lane 0
   word_t      field;

   logic       valid_q;
   logic       err_q;
   word_t      data_q;

   assign rd_row_o = rd_cmd_i.addr[ADDR_W-1:2];
   assign off      = rd_cmd_i.addr[1:0];
   assign sgn      = rd_cmd_i.sgn;
   assign bad      = misaligned(rd_cmd_i.size, off);

   assign shifted = row_data_i >> {off, 3'b000};

   // mask to the size, then fill with the field's top bit when signed
   always_comb begin
      case (rd_cmd_i.size)
         SIZE_BYTE: field = {{(DATA_W-8){sgn & shifted[7]}}, shifted[7:0]};
         SIZE_HALF: field = {{(DATA_W-16){sgn & shifted[15]}}, shifted[15:0]};
         SIZE_WORD: field = shifted;
         default:   field = '0;
      endcase
   end

   always_ff @(posedge clk_i) begin
      if (!rst_n_i) begin
         valid_q <= 1'b0;
         err_q   <= 1'b0;
         data_q  <= '0;
      end else begin
         valid_q <= rd_en_i;          // one pulse per strobe
         err_q   <= rd_en_i & bad;
         if (rd_en_i) begin
            data_q <= bad ? '0 : field;
         end
      end
   end

   assign rd_data_o  = data_q;
   assign rd_valid_o = valid_q;
   assign rd_err_o   = err_q;

endmodule

`default_nettype wire

/* src/regfile_2p.sv */
`timescale 1ns/1ps
`default_nettype none

module regfile_2p
   import regfile_pkg::*;
#(
   parameter int N      = 16,          // number of byte registers, multiple of 4
   parameter int ADDR_W = $clog2(N)    // byte address width
) (
   input  wire logic              clk_i,
   input  wire logic              rst_n_i,
   input  wire wr_req_t           wr_req_i,
   input  wire logic [ADDR_W-3:0] rd_row_i,
   output word_t                  rd_row_o
);

   localparam int LANES = DATA_W / 8;
   localparam int ROWS  = N / LANES;

   // each row is assembled from its byte registers
   wire [DATA_W-1:0] row_words [ROWS];

   genvar r;
   genvar l;

   generate
      for (r = 0; r < ROWS; r = r + 1) begin : g_rows
         for (l = 0; l < LANES; l = l + 1) begin : g_lanes
            logic       wen;
            logic [7:0] byte_q;

            // row hit and lane strobed
            assign wen = wr_req_i.en
                       & (wr_req_i.row == row_t'(r))
                       & wr_req_i.strb[l];

            always_ff @(posedge clk_i) begin
               if (!rst_n_i) begin
                  byte_q <= 8'h00;
               end else if (wen) begin
                  byte_q <= wr_req_i.data[l*8 +: 8];
               end
            end

            assign row_words[r][l*8 +: 8] = byte_q;
         end
      end
   endgenerate

   // read port, rows past the end of the bank read as zero
   always_comb begin
      if (int'(rd_row_i) < ROWS) begin
         rd_row_o = row_words[rd_row_i];
      end else begin
         rd_row_o = '0;
      end
   end

endmodule

`default_nettype wire

/* src/regfile_pkg.sv */
`default_nettype none

package regfile_pkg;

   // cpu word width, one row of the bank holds DATA_W/8 byte lanes
   localparam int DATA_W = 32;

   // access size, encoding 2'b11 is not a legal size
   typedef enum logic [1:0] {
      SIZE_BYTE = 2'b00,
      SIZE_HALF = 2'b01,
      SIZE_WORD = 2'b10
   } acc_size_t;

   typedef logic [DATA_W-1:0]   word_t;   // cpu data
   typedef logic [DATA_W/8-1:0] strb_t;   // one bit per byte lane
   typedef logic [7:0]          row_t;    // row index, upper bits idle for small banks
   typedef logic [9:0]          baddr_t;  // byte address as carried in a command

   // registered write, producer to bank
   typedef struct packed {
      logic  en;
      row_t  row;
      strb_t strb;
      word_t data;   // already shifted into its lanes
   } wr_req_t;

   // read command
   typedef struct packed {
      baddr_t    addr;
      acc_size_t size;
      logic      sgn;   // sign-extend the field
   } rd_cmd_t;

   // alignment rule shared by the write and read paths
   function automatic logic misaligned(acc_size_t size, logic [1:0] off);
      logic bad;
      case (size)
         SIZE_BYTE: bad = 1'b0;
         SIZE_HALF: bad = off[0];
         SIZE_WORD: bad = (off != 2'b00);
         default:   bad = 1'b1;   // undefined size is rejected as well
      endcase
      return bad;
   endfunction

endpackage

`default_nettype wire

/* src/regfile_top.sv */
`timescale 1ns/1ps
`default_nettype none

module regfile_top
   import regfile_pkg::*;
#(
   parameter int N      = 16,          // byte registers in the bank
   parameter int ADDR_W = $clog2(N)    // byte address width
) (
   input  wire logic              clk_i,
   input  wire logic              rst_n_i,
   // write port
   input  wire logic              wr_en_i,
   input  wire logic [ADDR_W-1:0] wr_addr_i,
   input  wire acc_size_t         wr_size_i,
   input  wire word_t             wr_data_i,
   output logic                   wr_err_o,
   // read port
   input  wire logic              rd_en_i,
   input  wire logic [ADDR_W-1:0] rd_addr_i,
   input  wire acc_size_t         rd_size_i,
   input  wire logic              rd_sgn_i,
   output word_t                  rd_data_o,
   output logic                   rd_valid_o,
   output logic                   rd_err_o
);

   wr_req_t           wr_req;
   rd_cmd_t           rd_cmd;
   logic [ADDR_W-3:0] rd_row;
   word_t             row_data;

   always_comb begin
      rd_cmd = '0;
      rd_cmd.addr[ADDR_W-1:0] = rd_addr_i;
      rd_cmd.size = rd_size_i;
      rd_cmd.sgn  = rd_sgn_i;
   end

   bus_wr_align #(
      .ADDR_W(ADDR_W)
   ) wr_align_i (
      .clk_i    (clk_i),
      .rst_n_i  (rst_n_i),
      .wr_en_i  (wr_en_i),
      .wr_addr_i(wr_addr_i),
      .wr_size_i(wr_size_i),
      .wr_data_i(wr_data_i),
      .wr_req_o (wr_req),
      .wr_err_o (wr_err_o)
   );

   regfile_2p #(
      .N     (N),
      .ADDR_W(ADDR_W)
   ) bank_i (
      .clk_i   (clk_i),
      .rst_n_i (rst_n_i),
      .wr_req_i(wr_req),
      .rd_row_i(rd_row),
      .rd_row_o(row_data)
   );

   rd_extract #(
      .ADDR_W(ADDR_W)
   ) rd_extract_i (
      .clk_i     (clk_i),
      .rst_n_i   (rst_n_i),
      .rd_en_i   (rd_en_i),
      .rd_cmd_i  (rd_cmd),
      .rd_row_o  (rd_row),
      .row_data_i(row_data),
      .rd_data_o (rd_data_o),
      .rd_valid_o(rd_valid_o),
      .rd_err_o  (rd_err_o)
   );

endmodule

`default_nettype wire
